// File: lsu_pkg.sv
// ----------------------------
// shared widths, cause codes and request types for the load/store front end
// bare translation only, float and AMO operators are not encoded
// ----------------------------
package lsu_pkg;

    localparam int unsigned XLEN          = 64;
    localparam int unsigned VLEN          = 39;
    localparam int unsigned PLEN          = 56;
    // bits SV-1 .. XLEN-1 of the address sum must all be equal
    localparam int unsigned SV            = 39;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned BE_BITS       = 8;

    // ----------------------------
    // exception causes
    // ----------------------------
    localparam logic [XLEN-1:0] LD_ADDR_MISALIGNED = 64'd4;
    localparam logic [XLEN-1:0] LD_ACCESS_FAULT    = 64'd5;
    localparam logic [XLEN-1:0] ST_ADDR_MISALIGNED = 64'd6;
    localparam logic [XLEN-1:0] ST_ACCESS_FAULT    = 64'd7;

    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE
    } fu_t;

    typedef enum logic [3:0] {
        LD, LW, LWU, LH, LHU, LB, LBU,
        SD, SW, SH, SB
    } op_t;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD,
        DOUBLE
    } size_t;

    typedef struct packed {
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] tval;
        logic            valid;
    } exception_t;

    // request as it arrives from issue
    typedef struct packed {
        fu_t                      fu;
        op_t                      operator;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          imm;
        // store data
        logic [XLEN-1:0]          operand_b;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // request as held in the bypass buffer
    typedef struct packed {
        logic                     valid;
        logic [VLEN-1:0]          vaddr;
        logic                     overflow;
        logic [XLEN-1:0]          data;
        logic [BE_BITS-1:0]       be;
        fu_t                      fu;
        op_t                      operator;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } lsu_ctrl_t;

    typedef struct packed {
        lsu_ctrl_t  ctrl;
        exception_t ex;
    } xlat_req_t;

    typedef struct packed {
        logic                     valid;
        logic                     is_store;
        logic [PLEN-1:0]          paddr;
        logic [BE_BITS-1:0]       be;
        logic [XLEN-1:0]          data;
        logic [TRANS_ID_BITS-1:0] trans_id;
        exception_t               ex;
    } mem_req_t;

    // access size follows from the operator alone
    function automatic size_t op_size(op_t op);
        case (op)
            LD, SD:       return DOUBLE;
            LW, LWU, SW:  return WORD;
            LH, LHU, SH:  return HALF;
            default:      return BYTE;
        endcase
    endfunction

endpackage

// File: lsu_agu.sv
// ----------------------------
// address generation, purely combinational
// the sum is truncated to VLEN, overflow flags mixed upper bits
// ----------------------------
module lsu_agu (
    input  lsu_pkg::fu_data_t  fu_data_i,
    input  logic               lsu_valid_i,
    output lsu_pkg::lsu_ctrl_t lsu_req_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0]    vaddr_xlen;
    logic [VLEN-1:0]    vaddr;
    logic               overflow;
    logic [BE_BITS-1:0] be;
    size_t              size;

    // signed add, then keep the virtual address bits
    assign vaddr_xlen = $unsigned($signed(fu_data_i.imm) + $signed(fu_data_i.operand_a));
    assign vaddr      = vaddr_xlen[VLEN-1:0];

    // upper part must be a pure sign extension
    assign overflow = !((&vaddr_xlen[XLEN-1:SV-1]) || !(|vaddr_xlen[XLEN-1:SV-1]));

    assign size = op_size(fu_data_i.operator);

    // ----------------------------
    // byte enable
    // ----------------------------
    always_comb begin
        case (size)
            BYTE:    be = 8'h01 << vaddr[2:0];
            HALF:    be = 8'h03 << vaddr[2:0];
            WORD:    be = 8'h0F << vaddr[2:0];
            default: be = 8'hFF;
        endcase
    end

    always_comb begin
        lsu_req_o.valid    = lsu_valid_i;
        lsu_req_o.vaddr    = vaddr;
        lsu_req_o.overflow = overflow;
        lsu_req_o.data     = fu_data_i.operand_b;
        lsu_req_o.be       = be;
        lsu_req_o.fu       = fu_data_i.fu;
        lsu_req_o.operator = fu_data_i.operator;
        lsu_req_o.trans_id = fu_data_i.trans_id;
    end

endmodule

// File: lsu_bypass.sv
// ----------------------------
// two-entry request buffer between AGU and dispatch
// an empty buffer shows the incoming request directly
// new requests are only expected while ready_o is high
// ----------------------------
module lsu_bypass (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  lsu_pkg::lsu_ctrl_t lsu_req_i,
    input  logic               pop_ld_i,
    input  logic               pop_st_i,
    output lsu_pkg::lsu_ctrl_t lsu_ctrl_o,
    output logic               ready_o
);
    import lsu_pkg::*;

    lsu_ctrl_t [1:0] mem_d, mem_q;
    logic            rd_ptr_d, rd_ptr_q;
    logic            wr_ptr_d, wr_ptr_q;
    logic [1:0]      cnt_d, cnt_q;
    logic            empty;
    logic            push;
    logic            pop;

    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;
    assign push    = lsu_req_i.valid;
    assign pop     = pop_ld_i | pop_st_i;

    // ----------------------------
    // next state
    // ----------------------------
    always_comb begin
        mem_d    = mem_q;
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;

        // the request is always written, even when it pops right away
        if (push) begin
            mem_d[wr_ptr_q] = lsu_req_i;
            wr_ptr_d        = ~wr_ptr_q;
        end

        if (pop) begin
            mem_d[rd_ptr_q].valid = 1'b0;
            rd_ptr_d              = ~rd_ptr_q;
        end

        case ({push, pop})
            2'b10:   cnt_d = cnt_q + 2'd1;
            2'b01:   cnt_d = cnt_q - 2'd1;
            default: cnt_d = cnt_q;
        endcase

        if (flush_i) begin
            mem_d    = '0;
            rd_ptr_d = 1'b0;
            wr_ptr_d = 1'b0;
            cnt_d    = 2'd0;
        end
    end

    // head of the buffer, or the new request when nothing is stored
    always_comb begin
        if (empty) begin
            lsu_ctrl_o = lsu_req_i;
        end else begin
            lsu_ctrl_o = mem_q[rd_ptr_q];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_q    <= '0;
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            mem_q    <= mem_d;
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

endmodule

// File: lsu_dispatch.sv
// ----------------------------
// alignment and overflow check on the buffer head, then issue
// access fault overrides misalignment, fu NONE never pops
// ----------------------------
module lsu_dispatch (
    input  logic               en_ld_st_translation_i,
    input  lsu_pkg::lsu_ctrl_t lsu_ctrl_i,
    input  logic               ld_ready_i,
    input  logic               st_ready_i,
    output logic               pop_ld_o,
    output logic               pop_st_o,
    output logic               issue_o,
    output lsu_pkg::xlat_req_t xlat_req_o
);
    import lsu_pkg::*;

    logic       misaligned;
    logic       is_load;
    logic       is_store;
    exception_t ex;

    assign is_load  = (lsu_ctrl_i.fu == LOAD);
    assign is_store = (lsu_ctrl_i.fu == STORE);

    // ----------------------------
    // misalignment by access size
    // ----------------------------
    always_comb begin
        misaligned = 1'b0;
        if (lsu_ctrl_i.valid) begin
            case (op_size(lsu_ctrl_i.operator))
                DOUBLE:  misaligned = (lsu_ctrl_i.vaddr[2:0] != 3'b000);
                WORD:    misaligned = (lsu_ctrl_i.vaddr[1:0] != 2'b00);
                HALF:    misaligned = lsu_ctrl_i.vaddr[0];
                // a byte is always aligned
                default: misaligned = 1'b0;
            endcase
        end
    end

    always_comb begin
        ex = '0;
        if (misaligned && (is_load || is_store)) begin
            ex.cause = is_load ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
            ex.tval  = {{(XLEN-VLEN){1'b0}}, lsu_ctrl_i.vaddr};
            ex.valid = 1'b1;
        end
        // overflow only matters with translation on
        if (lsu_ctrl_i.valid && en_ld_st_translation_i && lsu_ctrl_i.overflow &&
            (is_load || is_store)) begin
            ex.cause = is_load ? LD_ACCESS_FAULT : ST_ACCESS_FAULT;
            ex.tval  = {{(XLEN-VLEN){1'b0}}, lsu_ctrl_i.vaddr};
            ex.valid = 1'b1;
        end
    end

    // ----------------------------
    // issue decision
    // ----------------------------
    assign pop_ld_o = lsu_ctrl_i.valid && is_load && ld_ready_i;
    assign pop_st_o = lsu_ctrl_i.valid && is_store && st_ready_i;
    assign issue_o  = pop_ld_o | pop_st_o;

    assign xlat_req_o.ctrl = lsu_ctrl_i;
    assign xlat_req_o.ex   = ex;

endmodule

// File: lsu_translate.sv
// ----------------------------
// bare translation register then output register
// mem_req_o.valid follows an issue by exactly two cycles
// ----------------------------
module lsu_translate (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               issue_i,
    input  lsu_pkg::xlat_req_t xlat_req_i,
    output lsu_pkg::mem_req_t  mem_req_o
);
    import lsu_pkg::*;

    mem_req_t xlat_d;
    mem_req_t xlat_q;
    mem_req_t out_q;

    // bare mode, physical address is the zero-extended virtual one
    always_comb begin
        xlat_d.valid    = issue_i;
        xlat_d.is_store = (xlat_req_i.ctrl.fu == STORE);
        xlat_d.paddr    = {{(PLEN-VLEN){1'b0}}, xlat_req_i.ctrl.vaddr};
        xlat_d.be       = xlat_req_i.ctrl.be;
        xlat_d.data     = xlat_req_i.ctrl.data;
        xlat_d.trans_id = xlat_req_i.ctrl.trans_id;
        xlat_d.ex       = xlat_req_i.ex;
    end

    // ----------------------------
    // translation register
    // ----------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            xlat_q <= '0;
        end else begin
            xlat_q <= xlat_d;
        end
    end

    // ----------------------------
    // output register
    // ----------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_q <= '0;
        end else begin
            out_q <= xlat_q;
        end
    end

    assign mem_req_o = out_q;

endmodule

// File: lsu_top.sv
// ----------------------------
// load/store front end: AGU, bypass buffer, dispatch, translation
// no MMU, lsu_valid_i only while lsu_ready_o is high
// ----------------------------
module lsu_top (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              lsu_valid_i,
    input  lsu_pkg::fu_data_t fu_data_i,
    output logic              lsu_ready_o,
    input  logic              en_ld_st_translation_i,
    input  logic              ld_ready_i,
    input  logic              st_ready_i,
    output lsu_pkg::mem_req_t mem_req_o
);
    import lsu_pkg::*;

    lsu_ctrl_t lsu_req;
    lsu_ctrl_t lsu_ctrl;
    logic      pop_ld;
    logic      pop_st;
    logic      issue;
    xlat_req_t xlat_req;

    lsu_agu i_agu (
        .fu_data_i   ( fu_data_i   ),
        .lsu_valid_i ( lsu_valid_i ),
        .lsu_req_o   ( lsu_req     )
    );

    lsu_bypass i_bypass (
        .clk_i      ( clk_i       ),
        .rst_ni     ( rst_ni      ),
        .flush_i    ( flush_i     ),
        .lsu_req_i  ( lsu_req     ),
        .pop_ld_i   ( pop_ld      ),
        .pop_st_i   ( pop_st      ),
        .lsu_ctrl_o ( lsu_ctrl    ),
        .ready_o    ( lsu_ready_o )
    );

    lsu_dispatch i_dispatch (
        .en_ld_st_translation_i ( en_ld_st_translation_i ),
        .lsu_ctrl_i             ( lsu_ctrl               ),
        .ld_ready_i             ( ld_ready_i             ),
        .st_ready_i             ( st_ready_i             ),
        .pop_ld_o               ( pop_ld                 ),
        .pop_st_o               ( pop_st                 ),
        .issue_o                ( issue                  ),
        .xlat_req_o             ( xlat_req               )
    );

    lsu_translate i_translate (
        .clk_i      ( clk_i     ),
        .rst_ni     ( rst_ni    ),
        .issue_i    ( issue     ),
        .xlat_req_i ( xlat_req  ),
        .mem_req_o  ( mem_req_o )
    );

endmodule

// File: tb_lsu_top.sv
// ----------------------------
// random load/store traffic against a cycle model of the front end
// requests are only offered while the model predicts an empty buffer
// fu NONE is never generated, so the buffer always drains
// ----------------------------
module tb_lsu_top;
    import lsu_pkg::*;

    localparam int N_REQ          = 300;
    localparam int TIMEOUT_CYCLES = 4 * N_REQ + 100;

    logic      clk_i;
    logic      rst_ni;
    logic      flush_i;
    logic      lsu_valid_i;
    fu_data_t  fu_data_i;
    logic      lsu_ready_o;
    logic      en_ld_st_translation_i;
    logic      ld_ready_i;
    logic      st_ready_i;
    mem_req_t  mem_req_o;

    integer    seed;
    int        errors;
    int        sent;
    int        issued;
    int        flushes;
    int        drain;
    int        cycle_cnt;

    // the model keeps one queue for the buffer and one slot per cycle for outputs
    fu_data_t  q_data[$];
    mem_req_t  exp_mem[4];
    logic [1:0] slot;

    lsu_top uut (
        .clk_i                  ( clk_i                  ),
        .rst_ni                 ( rst_ni                 ),
        .flush_i                ( flush_i                ),
        .lsu_valid_i            ( lsu_valid_i            ),
        .fu_data_i              ( fu_data_i              ),
        .lsu_ready_o            ( lsu_ready_o            ),
        .en_ld_st_translation_i ( en_ld_st_translation_i ),
        .ld_ready_i             ( ld_ready_i             ),
        .st_ready_i             ( st_ready_i             ),
        .mem_req_o              ( mem_req_o              )
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ----------------------------
    // reference rules
    // ----------------------------
    function automatic int access_bytes(op_t op);
        case (op)
            LD, SD:      return 8;
            LW, LWU, SW: return 4;
            LH, LHU, SH: return 2;
            default:     return 1;
        endcase
    endfunction

    function automatic mem_req_t expected_mem_req(fu_data_t d, logic en);
        logic [63:0] sum;
        logic [38:0] va;
        logic        ovf;
        logic        mis;
        int          nbytes;
        logic [15:0] be_w;
        mem_req_t    r;
        sum    = d.operand_a + d.imm;
        va     = sum[38:0];
        ovf    = !((sum[63:38] == {26{1'b1}}) || (sum[63:38] == 26'd0));
        nbytes = access_bytes(d.operator);
        mis    = (va[2:0] % nbytes) != 0;
        if (nbytes == 8) begin
            be_w = 16'h00FF;
        end else begin
            be_w = ((16'd1 << nbytes) - 16'd1) << va[2:0];
        end
        r          = '0;
        r.valid    = 1'b1;
        r.is_store = (d.fu == STORE);
        r.paddr    = {17'd0, va};
        r.be       = be_w[7:0];
        r.data     = d.operand_b;
        r.trans_id = d.trans_id;
        // access fault wins over misalignment
        if (ovf && en) begin
            r.ex.cause = (d.fu == LOAD) ? LD_ACCESS_FAULT : ST_ACCESS_FAULT;
            r.ex.tval  = {25'd0, va};
            r.ex.valid = 1'b1;
        end else if (mis) begin
            r.ex.cause = (d.fu == LOAD) ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
            r.ex.tval  = {25'd0, va};
            r.ex.valid = 1'b1;
        end
        return r;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAIL %s got %h expected %h (cycle %0d)", name, got, exp, cycle_cnt);
        end
    endtask

    // ----------------------------
    // stimulus
    // ----------------------------
    task automatic make_request(output fu_data_t req);
        int unsigned op_n;
        int unsigned mode;
        logic [38:0] a39;
        logic [11:0] i12;
        op_n         = {$random(seed)} % 11;
        mode         = {$random(seed)} % 8;
        req.operator = op_t'(op_n);
        req.fu       = (op_n < 7) ? LOAD : STORE;
        a39          = {$random(seed), $random(seed)};
        i12          = $random(seed);
        // mostly sign-extended addresses, sometimes mixed upper bits
        if (mode == 0) begin
            req.operand_a = {$random(seed), $random(seed)};
        end else begin
            req.operand_a = {{25{a39[38]}}, a39};
        end
        req.imm = {{52{i12[11]}}, i12};
        if (mode >= 4) begin
            req.operand_a[2:0] = 3'b000;
            req.imm[2:0]       = 3'b000;
        end
        req.operand_b = {$random(seed), $random(seed)};
        req.trans_id  = $random(seed);
    endtask

    task automatic drive_inputs();
        fu_data_t req;
        logic     flush;
        make_request(req);
        flush = ({$random(seed)} % 24) == 0;
        fu_data_i              <= req;
        flush_i                <= flush;
        ld_ready_i             <= ({$random(seed)} % 8) < 5;
        st_ready_i             <= ({$random(seed)} % 8) < 5;
        en_ld_st_translation_i <= $random(seed);
        if (flush) begin
            flushes = flushes + 1;
        end
        // the model queue already holds the state of the coming cycle
        if (sent < N_REQ && q_data.size() == 0 && ({$random(seed)} % 4) != 0) begin
            lsu_valid_i <= 1'b1;
            sent = sent + 1;
        end else begin
            lsu_valid_i <= 1'b0;
        end
    endtask

    // ----------------------------
    // model step and output check at the falling edge
    // ----------------------------
    task automatic step_model();
        mem_req_t exp;
        fu_data_t head;
        logic     have_head;
        logic     popped;
        exp = exp_mem[slot];
        compare_value("lsu_ready_o", lsu_ready_o, q_data.size() == 0);
        compare_value("mem_req_o.valid", mem_req_o.valid, exp.valid);
        if (exp.valid) begin
            compare_value("mem_req_o.is_store", mem_req_o.is_store, exp.is_store);
            compare_value("mem_req_o.paddr", mem_req_o.paddr, exp.paddr);
            compare_value("mem_req_o.be", mem_req_o.be, exp.be);
            compare_value("mem_req_o.data", mem_req_o.data, exp.data);
            compare_value("mem_req_o.trans_id", mem_req_o.trans_id, exp.trans_id);
            compare_value("mem_req_o.ex.cause", mem_req_o.ex.cause, exp.ex.cause);
            compare_value("mem_req_o.ex.tval", mem_req_o.ex.tval, exp.ex.tval);
            compare_value("mem_req_o.ex.valid", mem_req_o.ex.valid, exp.ex.valid);
        end
        exp_mem[slot] = '0;

        have_head = 1'b0;
        head      = '0;
        if (q_data.size() > 0) begin
            head      = q_data[0];
            have_head = 1'b1;
        end else if (lsu_valid_i) begin
            head      = fu_data_i;
            have_head = 1'b1;
        end
        popped = have_head && ((head.fu == LOAD && ld_ready_i) ||
                               (head.fu == STORE && st_ready_i));
        if (popped) begin
            exp_mem[slot + 2'd2] = expected_mem_req(head, en_ld_st_translation_i);
            issued = issued + 1;
        end
        if (lsu_valid_i) begin
            q_data.push_back(fu_data_i);
        end
        if (popped) begin
            void'(q_data.pop_front());
        end
        // issue is decided before the flush clears the buffer
        if (flush_i) begin
            q_data.delete();
        end
        slot = slot + 2'd1;
    endtask

    initial begin
        seed      = 32'h5507;
        errors    = 0;
        sent      = 0;
        issued    = 0;
        flushes   = 0;
        drain     = 0;
        cycle_cnt = 0;
        slot      = 2'd0;
        for (int i = 0; i < 4; i++) begin
            exp_mem[i] = '0;
        end
        clk_i                  = 1'b0;
        rst_ni                 = 1'b0;
        flush_i                = 1'b0;
        lsu_valid_i            = 1'b0;
        fu_data_i              = '0;
        en_ld_st_translation_i = 1'b0;
        ld_ready_i             = 1'b0;
        st_ready_i             = 1'b0;

        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        // first cycle out of reset with idle inputs
        @(negedge clk_i);
        step_model();

        while (sent < N_REQ || q_data.size() != 0 || drain < 3) begin
            @(posedge clk_i);
            drive_inputs();
            @(negedge clk_i);
            step_model();
            if (sent == N_REQ && q_data.size() == 0) begin
                drain = drain + 1;
            end
        end

        $display("requests sent %0d, issued %0d, flushes %0d, errors %0d",
                 sent, issued, flushes, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
lsu_pkg.sv
lsu_agu.sv
lsu_bypass.sv
lsu_dispatch.sv
lsu_translate.sv
lsu_top.sv
tb_lsu_top.sv

// File: Bender.yml
package:
  name: lsu_top

sources:
  - lsu_pkg.sv
  - lsu_agu.sv
  - lsu_bypass.sv
  - lsu_dispatch.sv
  - lsu_translate.sv
  - lsu_top.sv
  - target: test
    files:
      - tb_lsu_top.sv
